/* source/tile_defs.svh */
`ifndef TILE_DEFS_SVH
`define TILE_DEFS_SVH

// physical address and data word
`define PADDR_WIDTH 40
`define DATA_WIDTH 64

// instruction fetch port and data port
`define NUM_SRC 2

// everything at or above this goes to DRAM
`define DRAM_BASE 40'h00_8000_0000

// device field of a local address
`define CFG_DEV_ID 4'd2

// configuration register offsets within the cfg device
`define CFG_FREEZE_OFS 20'h0_0004
`define CFG_NPC_OFS 20'h0_0008
`define CFG_CORE_ID_OFS 20'h0_000c
`define CFG_HIO_MASK_OFS 20'h0_001c

// configuration field widths
`define CORE_ID_WIDTH 6
`define HIO_WIDTH 4

`endif

/* source/addr_map_pkg.sv */
`include "tile_defs.svh"

package addr_map_pkg;

  // local view of a physical address
  //   hio    39:36
  //   unused 35:30
  //   tile   29:24
  //   dev    23:20
  //   offset 19:0
  typedef struct packed {
    logic [`HIO_WIDTH-1:0]     hio;
    logic [5:0]                unused;
    logic [`CORE_ID_WIDTH-1:0] tile;
    logic [3:0]                dev;
    logic [19:0]               offset;
  } tile_local_addr_t;

  // same 40 bits, either compared whole against the DRAM base
  // or split into the local fields
  typedef union packed {
    logic [`PADDR_WIDTH-1:0] raw;
    tile_local_addr_t        local_addr;
  } tile_addr_u;

  // devices that remain in the tile
  typedef enum logic {
    dest_cfg      = 1'b0,
    dest_loopback = 1'b1
  } dest_e;

endpackage

/* source/mem_msg_pkg.sv */
`include "tile_defs.svh"

package mem_msg_pkg;

  import addr_map_pkg::*;

  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } opcode_e;

  // forward message, one beat per request
  typedef struct packed {
    opcode_e                 opcode;
    tile_addr_u              addr;
    logic [`DATA_WIDTH-1:0]  data;
    logic                    src_id;
  } fwd_msg_t;

  // reverse message, src_id names the port the response returns to
  typedef struct packed {
    opcode_e                 opcode;
    logic [`DATA_WIDTH-1:0]  data;
    logic                    src_id;
  } rev_msg_t;

  // configuration state leaving the tile
  typedef struct packed {
    logic                      freeze;
    logic [`PADDR_WIDTH-1:0]   boot_npc;
    logic [`CORE_ID_WIDTH-1:0] core_id;
    logic [`HIO_WIDTH-1:0]     hio_mask;
    // room for the dropped cache mode fields
    logic [23:0]               spare;
  } cfg_bus_t;

endpackage

/* source/fwd_dest_decoder.sv */
`timescale 1ns/1ps

`include "tile_defs.svh"

module fwd_dest_decoder
  import addr_map_pkg::*;
  (input tile_addr_u                 addr_i
   , input [`CORE_ID_WIDTH-1:0]      core_id_i

   , output dest_e                   dest_o
   );

  logic is_local;
  logic is_hio_zero;
  logic is_cfg_dev;
  logic is_my_tile;
  logic is_cfg_fwd;

  // below DRAM base means the local field view applies
  assign is_local = (addr_i.raw < `DRAM_BASE);

  // nonzero hio belongs to another host I/O domain
  assign is_hio_zero = (addr_i.local_addr.hio == '0);

  assign is_cfg_dev = (addr_i.local_addr.dev == `CFG_DEV_ID);

  // tile field has to name this core
  assign is_my_tile = (addr_i.local_addr.tile == core_id_i);

  assign is_cfg_fwd = is_local & is_hio_zero & is_cfg_dev & is_my_tile;

  // other cores, other devices and DRAM all fall to loopback
  always_comb
  begin
    if (is_cfg_fwd)
    begin
      dest_o = dest_cfg;
    end
    else
    begin
      dest_o = dest_loopback;
    end
  end

endmodule

/* source/fwd_arbiter.sv */
`timescale 1ns/1ps

`include "tile_defs.svh"

module fwd_arbiter
  import addr_map_pkg::*;
  import mem_msg_pkg::*;
  (input                              clk_i
   , input                            arst_n_i

   , input fwd_msg_t [`NUM_SRC-1:0]   src_fwd_i
   , input [`NUM_SRC-1:0]             src_fwd_v_i
   , input dest_e [`NUM_SRC-1:0]      src_dest_i
   , output logic [`NUM_SRC-1:0]      src_fwd_ready_o

   , output fwd_msg_t                 cfg_fwd_o
   , output logic                     cfg_fwd_v_o
   , input                            cfg_fwd_ready_i
   , output fwd_msg_t                 lb_fwd_o
   , output logic                     lb_fwd_v_o
   , input                            lb_fwd_ready_i

   , input rev_msg_t                  cfg_rev_i
   , input                            cfg_rev_v_i
   , output logic                     cfg_rev_ready_o
   , input rev_msg_t                  lb_rev_i
   , input                            lb_rev_v_i
   , output logic                     lb_rev_ready_o

   , output rev_msg_t [`NUM_SRC-1:0]  src_rev_o
   , output logic [`NUM_SRC-1:0]      src_rev_v_o
   , input [`NUM_SRC-1:0]             src_rev_ready_i
   );

  logic     busy_r;
  logic     prio_r;
  logic     sel;
  logic     any_v;
  fwd_msg_t fwd_msg;
  dest_e    fwd_dest;
  logic     dest_ready;
  logic     fwd_fire;
  rev_msg_t rev_msg;
  logic     rev_v;
  logic     rev_fire;

  // favoured source first, else the other one
  assign sel   = src_fwd_v_i[prio_r] ? prio_r : ~prio_r;
  assign any_v = |src_fwd_v_i;

  // stamp the granted port so the response finds its way back
  always_comb
  begin
    fwd_msg        = src_fwd_i[sel];
    fwd_msg.src_id = sel;
  end
  assign fwd_dest = src_dest_i[sel];

  assign cfg_fwd_o   = fwd_msg;
  assign lb_fwd_o    = fwd_msg;
  assign cfg_fwd_v_o = ~busy_r & any_v & (fwd_dest == dest_cfg);
  assign lb_fwd_v_o  = ~busy_r & any_v & (fwd_dest == dest_loopback);

  assign dest_ready = (fwd_dest == dest_cfg) ? cfg_fwd_ready_i : lb_fwd_ready_i;
  assign fwd_fire   = ~busy_r & any_v & dest_ready;

  always_comb
  begin
    src_fwd_ready_o      = '0;
    src_fwd_ready_o[sel] = ~busy_r & dest_ready & src_fwd_v_i[sel];
  end

  // at most one slice holds a response since only one request is open
  assign rev_msg  = cfg_rev_v_i ? cfg_rev_i : lb_rev_i;
  assign rev_v    = cfg_rev_v_i | lb_rev_v_i;
  assign rev_fire = rev_v & src_rev_ready_i[rev_msg.src_id];

  assign cfg_rev_ready_o = src_rev_ready_i[cfg_rev_i.src_id];
  assign lb_rev_ready_o  = src_rev_ready_i[lb_rev_i.src_id];

  always_comb
  begin
    for (int i = 0; i < `NUM_SRC; i++)
    begin
      src_rev_o[i]   = rev_msg;
      src_rev_v_o[i] = rev_v & (rev_msg.src_id == 1'(i));
    end
  end

  // grant locks from the forward transfer to the response transfer
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      busy_r <= 1'b0;
      prio_r <= 1'b0;
    end
    else if (fwd_fire)
    begin
      busy_r <= 1'b1;
      prio_r <= ~sel;
    end
    else if (rev_fire)
    begin
      busy_r <= 1'b0;
    end
  end

  a_one_slice: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(cfg_fwd_v_o && lb_fwd_v_o));

  // a slice only answers a request this arbiter has let through
  a_rev_when_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rev_v |-> busy_r);

endmodule

/* source/cfg_slice.sv */
`timescale 1ns/1ps

`include "tile_defs.svh"

module cfg_slice
  import mem_msg_pkg::*;
  (input                    clk_i
   , input                  arst_n_i

   , input fwd_msg_t        fwd_i
   , input                  fwd_v_i
   , output logic           fwd_ready_o

   , output rev_msg_t       rev_o
   , output logic           rev_v_o
   , input                  rev_ready_i

   , output cfg_bus_t       cfg_bus_o
   );

  logic                      freeze_r;
  logic [`PADDR_WIDTH-1:0]   boot_npc_r;
  logic [`CORE_ID_WIDTH-1:0] core_id_r;
  logic [`HIO_WIDTH-1:0]     hio_mask_r;

  rev_msg_t               rev_r;
  logic                   rev_v_r;
  logic                   fwd_fire;
  logic                   is_write;
  logic [`DATA_WIDTH-1:0] rd_data;

  // no new request while a response waits
  assign fwd_ready_o = ~rev_v_r;
  assign fwd_fire    = fwd_v_i & fwd_ready_o;
  assign is_write    = (fwd_i.opcode == op_write);

  // zero-extended read, unknown offsets read as zero
  always_comb
  begin
    rd_data = '0;
    case (fwd_i.addr.local_addr.offset)
      `CFG_FREEZE_OFS:   rd_data[0] = freeze_r;
      `CFG_NPC_OFS:      rd_data[`PADDR_WIDTH-1:0] = boot_npc_r;
      `CFG_CORE_ID_OFS:  rd_data[`CORE_ID_WIDTH-1:0] = core_id_r;
      `CFG_HIO_MASK_OFS: rd_data[`HIO_WIDTH-1:0] = hio_mask_r;
      default:           rd_data = '0;
    endcase
  end

  // core comes out of reset frozen
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      freeze_r   <= 1'b1;
      boot_npc_r <= '0;
      core_id_r  <= '0;
      hio_mask_r <= '0;
    end
    else if (fwd_fire && is_write)
    begin
      case (fwd_i.addr.local_addr.offset)
        `CFG_FREEZE_OFS:   freeze_r   <= fwd_i.data[0];
        `CFG_NPC_OFS:      boot_npc_r <= fwd_i.data[`PADDR_WIDTH-1:0];
        `CFG_CORE_ID_OFS:  core_id_r  <= fwd_i.data[`CORE_ID_WIDTH-1:0];
        `CFG_HIO_MASK_OFS: hio_mask_r <= fwd_i.data[`HIO_WIDTH-1:0];
        default:           ;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      rev_v_r <= 1'b0;
    end
    else if (fwd_fire)
    begin
      rev_v_r <= 1'b1;
    end
    else if (rev_ready_i)
    begin
      rev_v_r <= 1'b0;
    end
  end

  // write responses carry zero data
  always_ff @(posedge clk_i)
  begin
    if (fwd_fire)
    begin
      rev_r.opcode <= fwd_i.opcode;
      rev_r.data   <= is_write ? '0 : rd_data;
      rev_r.src_id <= fwd_i.src_id;
    end
  end

  assign rev_o   = rev_r;
  assign rev_v_o = rev_v_r;

  assign cfg_bus_o.freeze   = freeze_r;
  assign cfg_bus_o.boot_npc = boot_npc_r;
  assign cfg_bus_o.core_id  = core_id_r;
  assign cfg_bus_o.hio_mask = hio_mask_r;
  assign cfg_bus_o.spare    = '0;

  a_rev_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rev_v_o && !rev_ready_i |=> rev_v_o && $stable(rev_o));

endmodule

/* source/loopback_slice.sv */
`timescale 1ns/1ps

module loopback_slice
  import mem_msg_pkg::*;
  (input                    clk_i
   , input                  arst_n_i

   , input fwd_msg_t        fwd_i
   , input                  fwd_v_i
   , output logic           fwd_ready_o

   , output rev_msg_t       rev_o
   , output logic           rev_v_o
   , input                  rev_ready_i
   );

  opcode_e opcode_r;
  logic    src_id_r;
  logic    rev_v_r;
  logic    fwd_fire;

  assign fwd_ready_o = ~rev_v_r;
  assign fwd_fire    = fwd_v_i & fwd_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      rev_v_r <= 1'b0;
    end
    else if (fwd_fire)
    begin
      rev_v_r <= 1'b1;
    end
    else if (rev_ready_i)
    begin
      rev_v_r <= 1'b0;
    end
  end

  // echo the header, data is always zero
  always_ff @(posedge clk_i)
  begin
    if (fwd_fire)
    begin
      opcode_r <= fwd_i.opcode;
      src_id_r <= fwd_i.src_id;
    end
  end

  assign rev_o.opcode = opcode_r;
  assign rev_o.data   = '0;
  assign rev_o.src_id = src_id_r;
  assign rev_v_o      = rev_v_r;

  a_rev_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rev_v_o && !rev_ready_i |=> rev_v_o && $stable(rev_o));

endmodule

/* source/tile_io_router.sv */
`timescale 1ns/1ps

`include "tile_defs.svh"

module tile_io_router
  import addr_map_pkg::*;
  import mem_msg_pkg::*;
  (input                              clk_i
   , input                            arst_n_i

   , input fwd_msg_t [`NUM_SRC-1:0]   src_fwd_i
   , input [`NUM_SRC-1:0]             src_fwd_v_i
   , output logic [`NUM_SRC-1:0]      src_fwd_ready_o

   , output rev_msg_t [`NUM_SRC-1:0]  src_rev_o
   , output logic [`NUM_SRC-1:0]      src_rev_v_o
   , input [`NUM_SRC-1:0]             src_rev_ready_i

   , output cfg_bus_t                 cfg_bus_o
   );

  cfg_bus_t              cfg_bus;
  dest_e [`NUM_SRC-1:0]  src_dest;

  fwd_msg_t cfg_fwd;
  logic     cfg_fwd_v;
  logic     cfg_fwd_ready;
  rev_msg_t cfg_rev;
  logic     cfg_rev_v;
  logic     cfg_rev_ready;

  fwd_msg_t lb_fwd;
  logic     lb_fwd_v;
  logic     lb_fwd_ready;
  rev_msg_t lb_rev;
  logic     lb_rev_v;
  logic     lb_rev_ready;

  // one decoder per source, tile match uses the live core id
  for (genvar i = 0; i < `NUM_SRC; i++)
  begin : g_dec
    fwd_dest_decoder u_dec
      (.addr_i(src_fwd_i[i].addr)
       ,.core_id_i(cfg_bus.core_id)
       ,.dest_o(src_dest[i])
       );
  end

  fwd_arbiter u_arb
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.src_fwd_i(src_fwd_i)
     ,.src_fwd_v_i(src_fwd_v_i)
     ,.src_dest_i(src_dest)
     ,.src_fwd_ready_o(src_fwd_ready_o)
     ,.cfg_fwd_o(cfg_fwd)
     ,.cfg_fwd_v_o(cfg_fwd_v)
     ,.cfg_fwd_ready_i(cfg_fwd_ready)
     ,.lb_fwd_o(lb_fwd)
     ,.lb_fwd_v_o(lb_fwd_v)
     ,.lb_fwd_ready_i(lb_fwd_ready)
     ,.cfg_rev_i(cfg_rev)
     ,.cfg_rev_v_i(cfg_rev_v)
     ,.cfg_rev_ready_o(cfg_rev_ready)
     ,.lb_rev_i(lb_rev)
     ,.lb_rev_v_i(lb_rev_v)
     ,.lb_rev_ready_o(lb_rev_ready)
     ,.src_rev_o(src_rev_o)
     ,.src_rev_v_o(src_rev_v_o)
     ,.src_rev_ready_i(src_rev_ready_i)
     );

  cfg_slice u_cfg
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.fwd_i(cfg_fwd)
     ,.fwd_v_i(cfg_fwd_v)
     ,.fwd_ready_o(cfg_fwd_ready)
     ,.rev_o(cfg_rev)
     ,.rev_v_o(cfg_rev_v)
     ,.rev_ready_i(cfg_rev_ready)
     ,.cfg_bus_o(cfg_bus)
     );

  loopback_slice u_lb
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.fwd_i(lb_fwd)
     ,.fwd_v_i(lb_fwd_v)
     ,.fwd_ready_o(lb_fwd_ready)
     ,.rev_o(lb_rev)
     ,.rev_v_o(lb_rev_v)
     ,.rev_ready_i(lb_rev_ready)
     );

  assign cfg_bus_o = cfg_bus;

endmodule

/* tests/tb_tile_io_router.sv */
`timescale 1ns/1ps

`include "tile_defs.svh"

module tb_tile_io_router
  import addr_map_pkg::*;
  import mem_msg_pkg::*;
  ();

  localparam int clk_period = 40;
  localparam int num_tests = 6;

  logic                      clk_i;
  logic                      arst_n_i;
  fwd_msg_t [`NUM_SRC-1:0]   src_fwd_i;
  logic [`NUM_SRC-1:0]       src_fwd_v_i;
  logic [`NUM_SRC-1:0]       src_fwd_ready_o;
  rev_msg_t [`NUM_SRC-1:0]   src_rev_o;
  logic [`NUM_SRC-1:0]       src_rev_v_o;
  logic [`NUM_SRC-1:0]       src_rev_ready_i;
  cfg_bus_t                  cfg_bus_o;

  // shadow configuration registers
  logic                      sh_freeze;
  logic [`PADDR_WIDTH-1:0]   sh_npc;
  logic [`CORE_ID_WIDTH-1:0] sh_core_id;
  logic [`HIO_WIDTH-1:0]     sh_hio;

  fwd_msg_t            req_q [`NUM_SRC][$];
  rev_msg_t            exp_q [`NUM_SRC][$];
  logic [`NUM_SRC-1:0] fwd_taken;
  logic [`NUM_SRC-1:0] held_v;
  rev_msg_t            held_msg [`NUM_SRC];
  logic                bp_en;
  logic [5:0]          cur_tile;
  logic [31:0]         lfsr_state = 32'h26e2;
  int                  errors;
  int                  checks;
  int                  tests_run;
  int                  test_err_start;
  int                  issued;
  int                  acc_cnt;
  int                  ans_cnt;

  tile_io_router UUT
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.src_fwd_i(src_fwd_i)
     ,.src_fwd_v_i(src_fwd_v_i)
     ,.src_fwd_ready_o(src_fwd_ready_o)
     ,.src_rev_o(src_rev_o)
     ,.src_rev_v_o(src_rev_v_o)
     ,.src_rev_ready_i(src_rev_ready_i)
     ,.cfg_bus_o(cfg_bus_o)
     );

  always #(clk_period / 2) clk_i = ~clk_i;

  // galois lfsr stepped once per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      r = {r[62:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
    end
    return r;
  endfunction

  function automatic logic [19:0] pick_ofs(input logic [1:0] k);
    case (k)
      2'd0: return `CFG_FREEZE_OFS;
      2'd1: return `CFG_NPC_OFS;
      2'd2: return `CFG_CORE_ID_OFS;
      default: return `CFG_HIO_MASK_OFS;
    endcase
  endfunction

  function automatic logic [39:0] local_addr(input logic [3:0] hio, input logic [5:0] tile,
                                             input logic [3:0] dev, input logic [19:0] ofs);
    return {hio, 6'h0, tile, dev, ofs};
  endfunction

  function automatic logic [39:0] cfg_addr(input logic [19:0] ofs);
    return local_addr(4'h0, cur_tile, `CFG_DEV_ID, ofs);
  endfunction

  // addresses that look like cfg but miss on one field
  function automatic logic [39:0] unclaimed_addr(input int kind, input logic [19:0] ofs);
    case (kind)
      0: return cfg_addr(ofs) | `DRAM_BASE;
      1: return local_addr(4'(rand_bits(4)) | 4'h1, cur_tile, `CFG_DEV_ID, ofs);
      2: return local_addr(4'h0, cur_tile, `CFG_DEV_ID + 4'd1 + 4'(rand_bits(3)), ofs);
      default: return local_addr(4'h0, cur_tile + 6'd1 + 6'(rand_bits(5)), `CFG_DEV_ID, ofs);
    endcase
  endfunction

  // expected response in acceptance order
  function automatic rev_msg_t ref_response(input fwd_msg_t req, input logic src);
    rev_msg_t    rsp;
    logic [39:0] a;
    logic        to_cfg;
    a = req.addr.raw;
    to_cfg = (a < `DRAM_BASE) && (a[39:36] == 4'h0) && (a[23:20] == `CFG_DEV_ID)
             && (a[29:24] == sh_core_id);
    rsp.opcode = req.opcode;
    rsp.src_id = src;
    rsp.data = '0;
    if (to_cfg && req.opcode == op_write)
    begin
      case (a[19:0])
        `CFG_FREEZE_OFS:   sh_freeze = req.data[0];
        `CFG_NPC_OFS:      sh_npc = req.data[39:0];
        `CFG_CORE_ID_OFS:  sh_core_id = req.data[5:0];
        `CFG_HIO_MASK_OFS: sh_hio = req.data[3:0];
        default:           ;
      endcase
    end
    else if (to_cfg)
    begin
      case (a[19:0])
        `CFG_FREEZE_OFS:   rsp.data = {63'h0, sh_freeze};
        `CFG_NPC_OFS:      rsp.data = {24'h0, sh_npc};
        `CFG_CORE_ID_OFS:  rsp.data = {58'h0, sh_core_id};
        `CFG_HIO_MASK_OFS: rsp.data = {60'h0, sh_hio};
        default:           rsp.data = '0;
      endcase
    end
    return rsp;
  endfunction

  function automatic cfg_bus_t shadow_bus();
    cfg_bus_t b;
    b.freeze = sh_freeze;
    b.boot_npc = sh_npc;
    b.core_id = sh_core_id;
    b.hio_mask = sh_hio;
    b.spare = '0;
    return b;
  endfunction

  task automatic issue(input logic src, input opcode_e op, input logic [39:0] addr,
                       input logic [63:0] data);
    fwd_msg_t m;
    m.opcode = op;
    m.addr.raw = addr;
    m.data = data;
    // arbiter stamps the port number over this
    m.src_id = 1'(rand_bits(1));
    req_q[src].push_back(m);
    issued++;
  endtask

  // wait until every queued request has been answered
  task automatic drain();
    while (req_q[0].size() != 0 || req_q[1].size() != 0 || src_fwd_v_i != '0
           || exp_q[0].size() != 0 || exp_q[1].size() != 0)
      @(negedge clk_i);
    @(negedge clk_i);
  endtask

  task automatic run_one(input logic src, input opcode_e op, input logic [39:0] addr,
                         input logic [63:0] data);
    issue(src, op, addr, data);
    drain();
  endtask

  task automatic end_test(input string name);
    int errs;
    if (acc_cnt != issued || ans_cnt != issued)
    begin
      $display("request count wrong: issued %0d, accepted %0d, answered %0d",
               issued, acc_cnt, ans_cnt);
      errors++;
    end
    errs = errors - test_err_start;
    tests_run++;
    $display("test %0d %s: %s, %0d errors", tests_run, name, (errs == 0) ? "ok" : "failed", errs);
    test_err_start = errors;
    issued = 0;
    acc_cnt = 0;
    ans_cnt = 0;
  endtask

  // drive a little after the rising edge
  always @(posedge clk_i)
  begin
    #2;
    for (int s = 0; s < `NUM_SRC; s++)
    begin
      if (fwd_taken[s])
      begin
        src_fwd_v_i[s] = 1'b0;
        fwd_taken[s] = 1'b0;
      end
      if (!src_fwd_v_i[s] && req_q[s].size() != 0)
      begin
        src_fwd_i[s] = req_q[s].pop_front();
        src_fwd_v_i[s] = 1'b1;
      end
      src_rev_ready_i[s] = bp_en ? (rand_bits(2) != 0) : 1'b1;
    end
  end

  // compare on the falling edge where everything has settled
  always @(negedge clk_i)
  begin
    rev_msg_t exp;
    if (arst_n_i)
    begin
      checks++;
      if (cfg_bus_o !== shadow_bus())
      begin
        $display("mismatch cfg_bus_o: got %h expected %h", cfg_bus_o, shadow_bus());
        errors++;
      end
      for (int s = 0; s < `NUM_SRC; s++)
      begin
        if (held_v[s] && !src_rev_v_o[s])
        begin
          $display("response on source %0d dropped before it was taken", s);
          errors++;
        end
        else if (held_v[s] && src_rev_o[s] !== held_msg[s])
        begin
          $display("mismatch src_rev_o[%0d] held: got %h expected %h", s, src_rev_o[s],
                   held_msg[s]);
          errors++;
        end
        if (src_rev_v_o[s] && src_rev_ready_i[s])
        begin
          ans_cnt++;
          checks++;
          if (exp_q[s].size() == 0)
          begin
            $display("response on source %0d with no open request", s);
            errors++;
          end
          else
          begin
            exp = exp_q[s].pop_front();
            if (src_rev_o[s] !== exp)
            begin
              $display("mismatch src_rev_o[%0d]: got %h expected %h", s, src_rev_o[s], exp);
              errors++;
            end
          end
        end
        held_v[s] = src_rev_v_o[s] && !src_rev_ready_i[s];
        held_msg[s] = src_rev_o[s];
        if (src_fwd_v_i[s] && src_fwd_ready_o[s])
        begin
          acc_cnt++;
          exp_q[s].push_back(ref_response(src_fwd_i[s], 1'(s)));
          fwd_taken[s] = 1'b1;
        end
      end
    end
  end

  initial
  begin
    #(num_tests * 200 * clk_period);
    $display("timeout: transactions still open after %0d cycles", num_tests * 200);
    $display("Result: FAILED");
    $finish;
  end

  initial
  begin
    logic [5:0]  old_tile;
    logic [5:0]  new_tile;
    logic [63:0] d;
    logic [19:0] ofs;
    logic        s;
    opcode_e     op;
    clk_i = 1'b0;
    arst_n_i = 1'b0;
    src_fwd_i = '0;
    src_fwd_v_i = '0;
    src_rev_ready_i = '1;
    fwd_taken = '0;
    held_v = '0;
    bp_en = 1'b0;
    cur_tile = '0;
    sh_freeze = 1'b1;
    sh_npc = '0;
    sh_core_id = '0;
    sh_hio = '0;
    errors = 0;
    checks = 0;
    tests_run = 0;
    test_err_start = 0;
    issued = 0;
    acc_cnt = 0;
    ans_cnt = 0;
    repeat (4) @(posedge clk_i);
    #2 arst_n_i = 1'b1;
    @(negedge clk_i);

    for (int k = 0; k < 4; k++)
    begin
      run_one(1'b0, op_read, cfg_addr(pick_ofs(2'(k))), '0);
      run_one(1'b1, op_read, cfg_addr(pick_ofs(2'(k))), '0);
    end
    end_test("reset values");

    for (int r = 0; r < 3; r++)
    begin
      for (int k = 0; k < 4; k++)
      begin
        d = rand_bits(64);
        ofs = pick_ofs(2'(k));
        run_one(1'(rand_bits(1)), op_write, cfg_addr(ofs), d);
        // tile match moves with the core id
        if (ofs == `CFG_CORE_ID_OFS)
          cur_tile = d[5:0];
        run_one(1'(rand_bits(1)), op_read, cfg_addr(ofs), '0);
      end
    end
    end_test("register access");

    for (int j = 0; j < 4; j++)
    begin
      for (int k = 0; k < 4; k++)
      begin
        ofs = pick_ofs(2'(k));
        run_one(1'b0, op_write, unclaimed_addr(j, ofs), rand_bits(64));
        run_one(1'b1, op_read, unclaimed_addr(j, ofs), '0);
      end
    end
    end_test("unclaimed addresses");

    old_tile = cur_tile;
    new_tile = 6'(rand_bits(6));
    if (new_tile == old_tile)
      new_tile = ~old_tile;
    run_one(1'b1, op_write, cfg_addr(`CFG_CORE_ID_OFS), {58'(rand_bits(58)), new_tile});
    cur_tile = new_tile;
    run_one(1'b0, op_read, cfg_addr(`CFG_CORE_ID_OFS), '0);
    run_one(1'b0, op_read, local_addr(4'h0, old_tile, `CFG_DEV_ID, `CFG_CORE_ID_OFS), '0);
    run_one(1'b1, op_write, local_addr(4'h0, old_tile, `CFG_DEV_ID, `CFG_HIO_MASK_OFS),
            rand_bits(64));
    run_one(1'b1, op_read, cfg_addr(`CFG_HIO_MASK_OFS), '0);
    end_test("tile follows core id");

    // both ports present on the same edges
    for (int k = 0; k < 4; k++)
    begin
      issue(1'b0, op_read, cfg_addr(pick_ofs(2'(k))), '0);
      issue(1'b1, op_write, cfg_addr(pick_ofs(2'(k) | 2'd1)), rand_bits(64));
      issue(1'b0, op_write, unclaimed_addr(0, pick_ofs(2'(k))), rand_bits(64));
      issue(1'b1, op_read, unclaimed_addr(1, pick_ofs(2'(k))), '0);
    end
    drain();
    end_test("contention");

    bp_en = 1'b1;
    for (int k = 0; k < 12; k++)
    begin
      s = 1'(rand_bits(1));
      op = rand_bits(1) ? op_write : op_read;
      ofs = pick_ofs(2'(rand_bits(2)));
      if (op == op_write && ofs == `CFG_CORE_ID_OFS)
        op = op_read;
      if (rand_bits(1))
        issue(s, op, cfg_addr(ofs), rand_bits(64));
      else
        issue(s, op, unclaimed_addr(int'(rand_bits(2)), ofs), rand_bits(64));
    end
    drain();
    bp_en = 1'b0;
    end_test("back-pressure");

    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

/* src.f */
+incdir+source
source/addr_map_pkg.sv
source/mem_msg_pkg.sv
source/fwd_dest_decoder.sv
source/fwd_arbiter.sv
source/cfg_slice.sv
source/loopback_slice.sv
source/tile_io_router.sv
tests/tb_tile_io_router.sv

/* Bender.yml */
package:
  name: tile_io_router

sources:
  - include_dirs:
      - source
    files:
      - source/addr_map_pkg.sv
      - source/mem_msg_pkg.sv
      - source/fwd_dest_decoder.sv
      - source/fwd_arbiter.sv
      - source/cfg_slice.sv
      - source/loopback_slice.sv
      - source/tile_io_router.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/tb_tile_io_router.sv
